// File: logic/trace_pkg.sv
`default_nettype none

package trace_pkg;

  // Data and program counter width
  localparam int unsigned XLEN = 32;

  // Register index width
  localparam int unsigned REG_ADDR_W = 5;

  // Argument register a0 is x10
  localparam logic [REG_ADDR_W-1:0] ARG_REG = 5'd10;

  // addi encoding fields
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [2:0] FUNCT3_ADDI = 3'b000;

  // Simulator control codes, taken from the addi immediate
  localparam logic [11:0] SIMCTRL_EXIT   = 12'd1;
  localparam logic [11:0] SIMCTRL_REPORT = 12'd2;
  localparam logic [11:0] SIMCTRL_PUTC   = 12'd3;

  // Event kinds
  localparam int unsigned EVT_KIND_W = 2;

  localparam logic [EVT_KIND_W-1:0] EVT_EXIT   = 2'd0;
  localparam logic [EVT_KIND_W-1:0] EVT_REPORT = 2'd1;
  localparam logic [EVT_KIND_W-1:0] EVT_PUTC   = 2'd2;

  // Configuration register map
  localparam int unsigned CFG_ADDR_W = 2;

  localparam logic [CFG_ADDR_W-1:0] CFG_CORE_EN = 2'd0;
  localparam logic [CFG_ADDR_W-1:0] CFG_FILTER  = 2'd1;

  // Bits inside the filter register
  localparam int unsigned FILTER_PUTC_BIT   = 0;
  localparam int unsigned FILTER_REPORT_BIT = 1;

  // Index width for n entries, at least one bit
  function automatic int unsigned idx_w(input int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

`default_nettype wire

// File: logic/trace_if.sv
`timescale 1ns/1ps
`default_nettype none

interface trace_if;
  import trace_pkg::*;

  // One committed instruction per valid strobe
  logic                  valid;
  logic [XLEN-1:0]       pc;
  logic [XLEN-1:0]       insn;
  // Writeback of the committed instruction
  logic                  wben;
  logic [REG_ADDR_W-1:0] wbreg;
  logic [XLEN-1:0]       wbdata;

  // Decoder side
  modport monitor (input valid, pc, insn, wben, wbreg, wbdata);

  // Core side
  modport source (output valid, pc, insn, wben, wbreg, wbdata);

endinterface

`default_nettype wire

// File: logic/core_trace_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module core_trace_decoder (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  trace_if.monitor                         trace,
  input  logic                             core_en_i,
  input  logic                             putc_en_i,
  input  logic                             report_en_i,
  output logic                             evt_valid_o,
  output logic [trace_pkg::EVT_KIND_W-1:0] evt_kind_o,
  output logic [trace_pkg::XLEN-1:0]       evt_data_o
);
  import trace_pkg::*;

  // Shadow copy of a0
  logic [XLEN-1:0]       a0_q;

  // Instruction fields
  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic [REG_ADDR_W-1:0] rd;
  logic [REG_ADDR_W-1:0] rs1;
  logic [11:0]           imm;

  // addi x0, x0, K form
  logic                  is_simctrl;

  // Next event
  logic                  evt_hit;
  logic [EVT_KIND_W-1:0] evt_kind_d;
  logic [XLEN-1:0]       evt_data_d;

  assign opcode = trace.insn[6:0];
  assign rd     = trace.insn[11:7];
  assign funct3 = trace.insn[14:12];
  assign rs1    = trace.insn[19:15];
  assign imm    = trace.insn[31:20];

  assign is_simctrl = (opcode == OPC_OP_IMM) && (funct3 == FUNCT3_ADDI) &&
                      (rd == '0) && (rs1 == '0);

  // Track committed writes to a0
  // Control instructions write x0, so no bypass is needed
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a0_q <= '0;
    end else if (trace.valid && trace.wben && (trace.wbreg == ARG_REG)) begin
      a0_q <= trace.wbdata;
    end
  end

  // Control code decode and filtering
  always_comb begin
    evt_hit    = 1'b0;
    evt_kind_d = EVT_EXIT;
    evt_data_d = a0_q;
    if (trace.valid && is_simctrl && core_en_i) begin
      case (imm)
        SIMCTRL_EXIT: begin
          // Exit always passes
          evt_hit    = 1'b1;
          evt_kind_d = EVT_EXIT;
        end
        SIMCTRL_REPORT: begin
          evt_hit    = report_en_i;
          evt_kind_d = EVT_REPORT;
        end
        SIMCTRL_PUTC: begin
          evt_hit    = putc_en_i;
          evt_kind_d = EVT_PUTC;
          // Character in low byte only
          evt_data_d = {{(XLEN-8){1'b0}}, a0_q[7:0]};
        end
        default: begin
          evt_hit = 1'b0;
        end
      endcase
    end
  end

  // Event strobe, one cycle after the trace strobe
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      evt_valid_o <= 1'b0;
    end else begin
      evt_valid_o <= evt_hit;
    end
  end

  // Event payload
  always_ff @(posedge clk_i) begin
    if (evt_hit) begin
      evt_kind_o <= evt_kind_d;
      evt_data_o <= evt_data_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/monitor_cfg.sv
`timescale 1ns/1ps
`default_nettype none

module monitor_cfg #(
  parameter int unsigned NUM_CORES = 4
) (
  input  logic                             clk_i,
  input  logic                             arst_n_i,
  input  logic                             cfg_we_i,
  input  logic [trace_pkg::CFG_ADDR_W-1:0] cfg_addr_i,
  input  logic [trace_pkg::XLEN-1:0]       cfg_wdata_i,
  output logic [NUM_CORES-1:0]             core_en_o,
  output logic                             putc_en_o,
  output logic                             report_en_o
);
  import trace_pkg::*;

  // Enable mask and filters, all on after reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      core_en_o   <= '1;
      putc_en_o   <= 1'b1;
      report_en_o <= 1'b1;
    end else if (cfg_we_i) begin
      case (cfg_addr_i)
        CFG_CORE_EN: begin
          // One bit per core
          core_en_o <= cfg_wdata_i[NUM_CORES-1:0];
        end
        CFG_FILTER: begin
          putc_en_o   <= cfg_wdata_i[FILTER_PUTC_BIT];
          report_en_o <= cfg_wdata_i[FILTER_REPORT_BIT];
        end
        default: begin
          // Undefined address, keep state
          core_en_o <= core_en_o;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/event_merge.sv
`timescale 1ns/1ps
`default_nettype none

module event_merge #(
  parameter int unsigned NUM_CORES      = 4,
  parameter int unsigned EVT_FIFO_DEPTH = 4
) (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  input  logic [NUM_CORES-1:0]                           in_valid_i,
  input  logic [NUM_CORES-1:0][trace_pkg::EVT_KIND_W-1:0] in_kind_i,
  input  logic [NUM_CORES-1:0][trace_pkg::XLEN-1:0]       in_data_i,
  output logic                                           evt_valid_o,
  output logic [trace_pkg::EVT_KIND_W-1:0]               evt_kind_o,
  output logic [trace_pkg::idx_w(NUM_CORES)-1:0]         evt_core_o,
  output logic [trace_pkg::XLEN-1:0]                     evt_data_o,
  output logic                                           overflow_o
);
  import trace_pkg::*;

  localparam int unsigned CORE_W  = idx_w(NUM_CORES);
  localparam int unsigned PTR_W   = idx_w(EVT_FIFO_DEPTH);
  localparam int unsigned CNT_W   = idx_w(EVT_FIFO_DEPTH + 1);
  localparam int unsigned ENTRY_W = EVT_KIND_W + XLEN;

  // Per-core queue status and head entry
  logic [NUM_CORES-1:0] q_nonempty;
  logic [NUM_CORES-1:0] q_full;
  logic [ENTRY_W-1:0]   q_head [NUM_CORES];

  // Round robin state
  logic [CORE_W-1:0]    last_q;
  logic                 sel_found;
  logic [CORE_W-1:0]    sel_idx;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(EVT_FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  for (genvar c = 0; c < NUM_CORES; c++) begin : g_queue
    logic [ENTRY_W-1:0] mem_q [EVT_FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               push;
    logic               pop;

    assign q_full[c]     = (count_q == CNT_W'(EVT_FIFO_DEPTH));
    assign q_nonempty[c] = (count_q != '0);
    assign q_head[c]     = mem_q[rd_ptr_q];

    // Full queue drops the event
    assign push = in_valid_i[c] && !q_full[c];
    assign pop  = sel_found && (sel_idx == CORE_W'(c));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        count_q  <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= ptr_next(wr_ptr_q);
        end
        if (pop) begin
          rd_ptr_q <= ptr_next(rd_ptr_q);
        end
        case ({push, pop})
          2'b10:   count_q <= count_q + 1'b1;
          2'b01:   count_q <= count_q - 1'b1;
          default: count_q <= count_q;
        endcase
      end
    end

    // Queue storage
    always_ff @(posedge clk_i) begin
      if (push) begin
        mem_q[wr_ptr_q] <= {in_kind_i[c], in_data_i[c]};
      end
    end
  end

  // Search starts after the core served last
  always_comb begin
    int unsigned cand;
    sel_found = 1'b0;
    sel_idx   = last_q;
    for (int unsigned k = 1; k <= NUM_CORES; k++) begin
      cand = (int'(last_q) + k) % NUM_CORES;
      if (!sel_found && q_nonempty[cand]) begin
        sel_found = 1'b1;
        sel_idx   = CORE_W'(cand);
      end
    end
  end

  // Output strobe, last served core and sticky overflow
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      evt_valid_o <= 1'b0;
      last_q      <= CORE_W'(NUM_CORES - 1);
      overflow_o  <= 1'b0;
    end else begin
      evt_valid_o <= sel_found;
      if (sel_found) begin
        last_q <= sel_idx;
      end
      if (|(in_valid_i & q_full)) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // Popped entry
  always_ff @(posedge clk_i) begin
    if (sel_found) begin
      {evt_kind_o, evt_data_o} <= q_head[sel_idx];
      evt_core_o               <= sel_idx;
    end
  end

endmodule

`default_nettype wire

// File: logic/term_collector.sv
`timescale 1ns/1ps
`default_nettype none

module term_collector #(
  parameter int unsigned NUM_CORES = 4
) (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic [NUM_CORES-1:0]                     exit_valid_i,
  input  logic [NUM_CORES-1:0][trace_pkg::XLEN-1:0] exit_code_i,
  input  logic [NUM_CORES-1:0]                     core_en_i,
  output logic [NUM_CORES-1:0]                     exited_o,
  output logic                                     fail_o,
  output logic                                     done_o
);
  import trace_pkg::*;

  // Any exit this cycle with a nonzero code
  logic bad_exit;

  always_comb begin
    bad_exit = 1'b0;
    for (int unsigned c = 0; c < NUM_CORES; c++) begin
      if (exit_valid_i[c] && (exit_code_i[c] != '0)) begin
        bad_exit = 1'b1;
      end
    end
  end

  // Exited bits and failure both stick until reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exited_o <= '0;
      fail_o   <= 1'b0;
    end else begin
      exited_o <= exited_o | exit_valid_i;
      if (bad_exit) begin
        fail_o <= 1'b1;
      end
    end
  end

  // Done once every enabled core has exited
  // Needs at least one enabled core
  assign done_o = (core_en_i != '0) && ((exited_o & core_en_i) == core_en_i);

endmodule

`default_nettype wire

// File: logic/trace_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

module trace_monitor_top #(
  parameter int unsigned NUM_CORES      = 4,
  parameter int unsigned EVT_FIFO_DEPTH = 4
) (
  input  logic                                           clk_i,
  input  logic                                           arst_n_i,
  // Writeback trace of every core
  input  logic [NUM_CORES-1:0]                           trace_valid_i,
  input  logic [NUM_CORES-1:0][trace_pkg::XLEN-1:0]       trace_pc_i,
  input  logic [NUM_CORES-1:0][trace_pkg::XLEN-1:0]       trace_insn_i,
  input  logic [NUM_CORES-1:0]                           trace_wben_i,
  input  logic [NUM_CORES-1:0][trace_pkg::REG_ADDR_W-1:0] trace_wbreg_i,
  input  logic [NUM_CORES-1:0][trace_pkg::XLEN-1:0]       trace_wbdata_i,
  // Configuration write
  input  logic                                           cfg_we_i,
  input  logic [trace_pkg::CFG_ADDR_W-1:0]               cfg_addr_i,
  input  logic [trace_pkg::XLEN-1:0]                     cfg_wdata_i,
  // Merged event stream
  output logic                                           evt_valid_o,
  output logic [trace_pkg::EVT_KIND_W-1:0]               evt_kind_o,
  output logic [trace_pkg::idx_w(NUM_CORES)-1:0]         evt_core_o,
  output logic [trace_pkg::XLEN-1:0]                     evt_data_o,
  output logic                                           overflow_o,
  // Termination
  output logic [NUM_CORES-1:0]                           exited_o,
  output logic                                           fail_o,
  output logic                                           done_o
);
  import trace_pkg::*;

  // Configuration
  logic [NUM_CORES-1:0]                  core_en;
  logic                                  putc_en;
  logic                                  report_en;

  // Decoder events
  logic [NUM_CORES-1:0]                  dec_valid;
  logic [NUM_CORES-1:0][EVT_KIND_W-1:0]  dec_kind;
  logic [NUM_CORES-1:0][XLEN-1:0]        dec_data;

  // Split by kind
  logic [NUM_CORES-1:0]                  exit_valid;
  logic [NUM_CORES-1:0]                  queue_valid;

  monitor_cfg #(
    .NUM_CORES (NUM_CORES)
  ) monitor_cfg_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .core_en_o   (core_en),
    .putc_en_o   (putc_en),
    .report_en_o (report_en)
  );

  for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
    trace_if trace_bus ();

    // Core side of the bundle, fed from the packed ports
    assign trace_bus.valid  = trace_valid_i[c];
    assign trace_bus.pc     = trace_pc_i[c];
    assign trace_bus.insn   = trace_insn_i[c];
    assign trace_bus.wben   = trace_wben_i[c];
    assign trace_bus.wbreg  = trace_wbreg_i[c];
    assign trace_bus.wbdata = trace_wbdata_i[c];

    core_trace_decoder core_trace_decoder_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .trace       (trace_bus.monitor),
      .core_en_i   (core_en[c]),
      .putc_en_i   (putc_en),
      .report_en_i (report_en),
      .evt_valid_o (dec_valid[c]),
      .evt_kind_o  (dec_kind[c]),
      .evt_data_o  (dec_data[c])
    );

    // Exits go to the collector, the rest to the queues
    assign exit_valid[c]  = dec_valid[c] && (dec_kind[c] == EVT_EXIT);
    assign queue_valid[c] = dec_valid[c] && (dec_kind[c] != EVT_EXIT);
  end

  event_merge #(
    .NUM_CORES      (NUM_CORES),
    .EVT_FIFO_DEPTH (EVT_FIFO_DEPTH)
  ) event_merge_inst (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (queue_valid),
    .in_kind_i   (dec_kind),
    .in_data_i   (dec_data),
    .evt_valid_o (evt_valid_o),
    .evt_kind_o  (evt_kind_o),
    .evt_core_o  (evt_core_o),
    .evt_data_o  (evt_data_o),
    .overflow_o  (overflow_o)
  );

  // Exit code is the a0 shadow carried by the event
  term_collector #(
    .NUM_CORES (NUM_CORES)
  ) term_collector_inst (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .exit_valid_i (exit_valid),
    .exit_code_i  (dec_data),
    .core_en_i    (core_en),
    .exited_o     (exited_o),
    .fail_o       (fail_o),
    .done_o       (done_o)
  );

endmodule

`default_nettype wire

// File: verification/trace_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module trace_monitor_tb;
  import trace_pkg::*;

  localparam int NC    = 4;
  localparam int DEPTH = 4;
  // Random phase lengths in cycles
  localparam int LEN_MIX   = 60;
  localparam int LEN_BURST = 24;
  localparam int DRAIN_MAX = 200;
  // Summed test lengths with a margin of two
  localparam int RUN_CYCLES  = 5 * LEN_MIX + LEN_BURST + 8 * DRAIN_MAX;
  localparam int WATCHDOG_NS = 2 * RUN_CYCLES * 8;

  logic                         clk_i = 1'b0;
  logic                         arst_n_i;
  logic [NC-1:0]                trace_valid_i;
  logic [NC-1:0][XLEN-1:0]      trace_pc_i;
  logic [NC-1:0][XLEN-1:0]      trace_insn_i;
  logic [NC-1:0]                trace_wben_i;
  logic [NC-1:0][REG_ADDR_W-1:0] trace_wbreg_i;
  logic [NC-1:0][XLEN-1:0]      trace_wbdata_i;
  logic                         cfg_we_i;
  logic [CFG_ADDR_W-1:0]        cfg_addr_i;
  logic [XLEN-1:0]              cfg_wdata_i;
  logic                         evt_valid_o;
  logic [EVT_KIND_W-1:0]        evt_kind_o;
  logic [idx_w(NC)-1:0]         evt_core_o;
  logic [XLEN-1:0]              evt_data_o;
  logic                         overflow_o;
  logic [NC-1:0]                exited_o;
  logic                         fail_o;
  logic                         done_o;

  // Stimulus for the next driven cycle
  logic                  nxt_valid [NC];
  logic [11:0]           nxt_code [NC];
  logic [XLEN-1:0]       nxt_insn [NC];
  logic                  nxt_wben [NC];
  logic [REG_ADDR_W-1:0] nxt_wbreg [NC];
  logic [XLEN-1:0]       nxt_wbdata [NC];
  logic                  nxt_cfg_we;
  logic [CFG_ADDR_W-1:0] nxt_cfg_addr;
  logic [XLEN-1:0]       nxt_cfg_wdata;

  // Reference model state
  logic [XLEN-1:0] a0_m [NC];
  logic [NC-1:0]   core_en_m;
  logic            putc_en_m;
  logic            report_en_m;
  logic [NC-1:0]   exited_m;
  logic            fail_m;
  // Expected queued events as {core, kind, data}
  logic [47:0]     exp_q [$];
  // Burst mode, entries the DUT dropped get skipped
  logic            allow_drop = 1'b0;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err0 = 0;
  logic [31:0] rng_state = 32'hbca5b87b;

  trace_monitor_top #(
    .NUM_CORES      (NC),
    .EVT_FIFO_DEPTH (DEPTH)
  ) trace_monitor_top_inst (.*);

  always #4 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  function automatic int first_of_core(input int c);
    for (int i = 0; i < exp_q.size(); i++) begin
      if (int'(exp_q[i][47:40]) == c) begin
        return i;
      end
    end
    return -1;
  endfunction

  // Merged stream against the head of that core's expected events
  always @(negedge clk_i) begin
    int idx;
    logic [47:0] got;
    if (arst_n_i && evt_valid_o) begin
      got = {8'(evt_core_o), 8'(evt_kind_o), evt_data_o};
      idx = first_of_core(int'(evt_core_o));
      while (allow_drop && idx >= 0 && exp_q[idx] != got) begin
        exp_q.delete(idx);
        idx = first_of_core(int'(evt_core_o));
      end
      if (idx < 0) begin
        $display("Event from core %0d matches no expected event", evt_core_o);
        errors++;
      end else begin
        if (exp_q[idx][39:32] != 8'(evt_kind_o)) begin
          $display("Mismatch evt_kind_o core %0d: got %h expected %h",
                   evt_core_o, evt_kind_o, exp_q[idx][39:32]);
          errors++;
        end
        if (exp_q[idx][31:0] != evt_data_o) begin
          $display("Mismatch evt_data_o core %0d: got %h expected %h",
                   evt_core_o, evt_data_o, exp_q[idx][31:0]);
          errors++;
        end
        exp_q.delete(idx);
      end
    end
  end

  task automatic clear_next();
    for (int c = 0; c < NC; c++) begin
      nxt_valid[c]  = 1'b0;
      nxt_code[c]   = '0;
      nxt_insn[c]   = '0;
      nxt_wben[c]   = 1'b0;
      nxt_wbreg[c]  = '0;
      nxt_wbdata[c] = '0;
    end
    nxt_cfg_we    = 1'b0;
    nxt_cfg_addr  = '0;
    nxt_cfg_wdata = '0;
  endtask

  // Model step for the cycle being driven, config after the traces
  task automatic model_cycle();
    for (int c = 0; c < NC; c++) begin
      if (nxt_valid[c] && core_en_m[c]) begin
        if (nxt_code[c] == SIMCTRL_EXIT) begin
          exited_m[c] = 1'b1;
          if (a0_m[c] != '0) fail_m = 1'b1;
        end else if (nxt_code[c] == SIMCTRL_REPORT && report_en_m) begin
          exp_q.push_back({8'(c), 8'(EVT_REPORT), a0_m[c]});
        end else if (nxt_code[c] == SIMCTRL_PUTC && putc_en_m) begin
          exp_q.push_back({8'(c), 8'(EVT_PUTC), 24'd0, a0_m[c][7:0]});
        end
      end
      if (nxt_valid[c] && nxt_wben[c] && nxt_wbreg[c] == ARG_REG) begin
        a0_m[c] = nxt_wbdata[c];
      end
    end
    if (nxt_cfg_we && nxt_cfg_addr == CFG_CORE_EN) core_en_m = nxt_cfg_wdata[NC-1:0];
    if (nxt_cfg_we && nxt_cfg_addr == CFG_FILTER) begin
      putc_en_m   = nxt_cfg_wdata[0];
      report_en_m = nxt_cfg_wdata[1];
    end
  endtask

  task automatic drive_cycle();
    @(negedge clk_i);
    for (int c = 0; c < NC; c++) begin
      trace_valid_i[c]  = nxt_valid[c];
      trace_pc_i[c]     = next_rand();
      trace_insn_i[c]   = nxt_insn[c];
      trace_wben_i[c]   = nxt_wben[c];
      trace_wbreg_i[c]  = nxt_wbreg[c];
      trace_wbdata_i[c] = nxt_wbdata[c];
    end
    cfg_we_i    = nxt_cfg_we;
    cfg_addr_i  = nxt_cfg_addr;
    cfg_wdata_i = nxt_cfg_wdata;
    model_cycle();
    clear_next();
  endtask

  task automatic put_write(input int c, input logic en, input logic [REG_ADDR_W-1:0] rd,
                           input logic [XLEN-1:0] d);
    logic [31:0] r;
    r = next_rand();
    nxt_valid[c]  = 1'b1;
    nxt_code[c]   = '0;
    // ALU register op, never a control instruction
    nxt_insn[c]   = {r[31:12], rd, 7'b0110011};
    nxt_wben[c]   = en;
    nxt_wbreg[c]  = rd;
    nxt_wbdata[c] = d;
  endtask

  task automatic put_ctrl(input int c, input logic [11:0] code);
    nxt_valid[c] = 1'b1;
    nxt_code[c]  = code;
    // addi x0, x0, code
    nxt_insn[c]  = {code, 5'd0, FUNCT3_ADDI, 5'd0, OPC_OP_IMM};
  endtask

  task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input logic [XLEN-1:0] data);
    nxt_cfg_we    = 1'b1;
    nxt_cfg_addr  = addr;
    nxt_cfg_wdata = data;
    drive_cycle();
  endtask

  task automatic do_reset();
    arst_n_i = 1'b0;
    clear_next();
    for (int c = 0; c < NC; c++) a0_m[c] = '0;
    core_en_m   = '1;
    putc_en_m   = 1'b1;
    report_en_m = 1'b1;
    exited_m    = '0;
    fail_m      = 1'b0;
    exp_q.delete();
    repeat (3) drive_cycle();
    arst_n_i = 1'b1;
  endtask

  // One core per cycle, code zero picks report or putc at random
  task automatic random_mix(input int cycles, input logic [11:0] code);
    logic [31:0] r;
    logic [REG_ADDR_W-1:0] rd;
    int c;
    for (int n = 0; n < cycles; n++) begin
      r  = next_rand();
      c  = int'(r[7:0]) % NC;
      rd = r[15:11];
      if (rd == ARG_REG) rd = 5'd11;
      case (r[10:8])
        3'd0, 3'd1: put_write(c, 1'b1, ARG_REG, next_rand());
        3'd2: put_write(c, 1'b1, rd, next_rand());
        // wben low, a0 untouched
        3'd3: put_write(c, 1'b0, ARG_REG, next_rand());
        default: put_ctrl(c, (code != '0) ? code : (r[16] ? SIMCTRL_REPORT : SIMCTRL_PUTC));
      endcase
      drive_cycle();
    end
  endtask

  // Idle traces while the queues empty
  task automatic wait_drained();
    int n;
    n = 0;
    while (exp_q.size() > 0 && n < DRAIN_MAX) begin
      drive_cycle();
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("Timed out with %0d expected events never emitted", exp_q.size());
      errors++;
      exp_q.delete();
    end
    repeat (2) drive_cycle();
  endtask

  task automatic check_term();
    logic done_m;
    // Done needs one enabled core and no enabled core still running
    done_m = 1'b0;
    for (int c = 0; c < NC; c++) begin
      if (core_en_m[c]) done_m = 1'b1;
    end
    for (int c = 0; c < NC; c++) begin
      if (core_en_m[c] && !exited_m[c]) done_m = 1'b0;
    end
    if (exited_o !== exited_m) begin
      $display("Mismatch exited_o: got %h expected %h", exited_o, exited_m);
      errors++;
    end
    if (fail_o !== fail_m) begin
      $display("Mismatch fail_o: got %h expected %h", fail_o, fail_m);
      errors++;
    end
    if (done_o !== done_m) begin
      $display("Mismatch done_o: got %h expected %h", done_o, done_m);
      errors++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    tests_run++;
    if (errors == test_err0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", num, name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  initial begin
    int k;
    int n;
    int quiet;
    arst_n_i       = 1'b0;
    trace_valid_i  = '0;
    trace_pc_i     = '0;
    trace_insn_i   = '0;
    trace_wben_i   = '0;
    trace_wbreg_i  = '0;
    trace_wbdata_i = '0;
    cfg_we_i       = 1'b0;
    cfg_addr_i     = '0;
    cfg_wdata_i    = '0;
    do_reset();

    random_mix(LEN_MIX, SIMCTRL_REPORT);
    wait_drained();
    if (overflow_o !== 1'b0) begin
      $display("Mismatch overflow_o: got %h expected %h", overflow_o, 1'b0);
      errors++;
    end
    end_test(1, "a0 shadow and report");

    random_mix(LEN_MIX, SIMCTRL_PUTC);
    wait_drained();
    if (overflow_o !== 1'b0) begin
      $display("Mismatch overflow_o: got %h expected %h", overflow_o, 1'b0);
      errors++;
    end
    end_test(2, "putc order per core");

    // Report only, then putc back on
    cfg_write(CFG_FILTER, 32'h2);
    random_mix(LEN_MIX, 12'd0);
    wait_drained();
    cfg_write(CFG_FILTER, 32'h3);
    random_mix(LEN_MIX, SIMCTRL_PUTC);
    wait_drained();
    end_test(3, "putc filter");

    // Core 2 off
    cfg_write(CFG_CORE_EN, 32'hb);
    random_mix(LEN_MIX, 12'd0);
    put_ctrl(2, SIMCTRL_EXIT);
    repeat (3) drive_cycle();
    check_term();
    for (int c = 0; c < NC; c++) begin
      if (c != 2) put_ctrl(c, SIMCTRL_EXIT);
    end
    drive_cycle();
    n = 0;
    while (!done_o && n < DRAIN_MAX) begin
      drive_cycle();
      n++;
    end
    if (!done_o) begin
      $display("done_o never rose after all enabled cores exited");
      errors++;
    end
    wait_drained();
    check_term();
    end_test(4, "core enable and done");

    do_reset();
    for (int c = 0; c < NC; c++) put_write(c, 1'b1, ARG_REG, '0);
    drive_cycle();
    for (int c = 0; c < NC; c++) put_ctrl(c, SIMCTRL_EXIT);
    repeat (3) drive_cycle();
    check_term();
    do_reset();
    k = int'(next_rand() % 32'(NC));
    put_write(k, 1'b1, ARG_REG, next_rand() | 32'h1);
    drive_cycle();
    put_ctrl(k, SIMCTRL_EXIT);
    repeat (3) drive_cycle();
    check_term();
    end_test(5, "exit codes");

    // Two putc rounds per a0 write on every core, faster than the drain
    do_reset();
    allow_drop = 1'b1;
    for (int i = 0; i < LEN_BURST; i++) begin
      for (int c = 0; c < NC; c++) begin
        if (i % 3 == 0) put_write(c, 1'b1, ARG_REG, next_rand());
        else put_ctrl(c, SIMCTRL_PUTC);
      end
      drive_cycle();
    end
    repeat (3) drive_cycle();
    quiet = 0;
    n = 0;
    while (quiet < 2 && n < DRAIN_MAX) begin
      @(negedge clk_i);
      quiet = evt_valid_o ? 0 : quiet + 1;
      n++;
    end
    if (quiet < 2) begin
      $display("Timed out waiting for the event queues to drain");
      errors++;
    end
    if (overflow_o !== 1'b1) begin
      $display("Mismatch overflow_o: got %h expected %h", overflow_o, 1'b1);
      errors++;
    end
    // Remaining entries were dropped by the DUT
    exp_q.delete();
    allow_drop = 1'b0;
    end_test(6, "overflow bursts");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
logic/trace_pkg.sv
logic/trace_if.sv
logic/core_trace_decoder.sv
logic/monitor_cfg.sv
logic/event_merge.sv
logic/term_collector.sv
logic/trace_monitor_top.sv
verification/trace_monitor_tb.sv

// File: Makefile
# Verilator build and run of the trace monitor testbench

VERILATOR ?= verilator
TOP       ?= trace_monitor_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
